// File: pixelPkg.sv
package pixelPkg;

    // RGB565 stores each pixel in two bytes
    localparam int BytesPerPixel = 2;

    // colour fields of one stored pixel
    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
    } rgb565T;

    // one pixel word as seen by the memory or by the output stage
    // the low byte lives at the even byte address
    typedef union packed {
        rgb565T rgb;
        struct packed {
            logic [7:0] hi;
            logic [7:0] lo;
        } bytes;
    } pixelWordT;

    // expanded colour sent to the display
    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb888T;

endpackage

// File: videoPkg.sv
package videoPkg;

    // timing flags for one scan position
    typedef struct packed {
        logic hSync;
        logic vSync;
        logic active;
    } videoSyncT;

    // one beat on the video output
    typedef struct packed {
        videoSyncT        sync;
        pixelPkg::rgb888T rgb;
    } videoOutT;

endpackage

// File: frameBuffer.sv
`timescale 1ns/10ps

module frameBuffer #(
    parameter int PixelWidth  = 64,
    parameter int PixelHeight = 32
) (
    input  logic                ClockA,
    input  logic                rstN,
    input  logic                wrEn,
    input  logic [$clog2(PixelWidth * PixelHeight * pixelPkg::BytesPerPixel)-1:0] wrAddr,
    input  logic [7:0]          wrData,
    input  logic [$clog2(PixelWidth * PixelHeight)-1:0] rdPixel,
    output pixelPkg::pixelWordT rdWord,
    output logic                clearBusy
);
    import pixelPkg::*;

    localparam int PixelCount = PixelWidth * PixelHeight;
    localparam int ByteCount  = PixelCount * BytesPerPixel;
    localparam int ByteAddrW  = $clog2(ByteCount);
    localparam int PixelAddrW = $clog2(PixelCount);

    // byte organized frame store
    logic [7:0] mem [ByteCount];

    logic [ByteAddrW-1:0] clearIdx;
    logic                 memWe;
    logic [ByteAddrW-1:0] memAddr;
    logic [7:0]           memData;
    logic [ByteAddrW-1:0] rdLoAddr;
    logic [ByteAddrW-1:0] rdHiAddr;

    // the clear sequence owns the write port until every byte is zero
    always_comb begin
        if (clearBusy) begin
            memWe   = 1'b1;
            memAddr = clearIdx;
            memData = 8'h00;
        end else begin
            memWe   = wrEn;
            memAddr = wrAddr;
            memData = wrData;
        end
    end

    always_ff @(posedge ClockA) begin
        if (memWe) begin
            mem[memAddr] <= memData;
        end
    end

    // one byte cleared per cycle after reset
    always_ff @(posedge ClockA) begin
        if (!rstN) begin
            clearIdx  <= '0;
            clearBusy <= 1'b1;
        end else if (clearBusy) begin
            clearIdx <= clearIdx + 1'b1;
            if (clearIdx == ByteAddrW'(ByteCount - 1)) begin
                clearBusy <= 1'b0;
            end
        end
    end

    // both bytes of the pixel are fetched together
    assign rdLoAddr = {rdPixel, 1'b0};
    assign rdHiAddr = {rdPixel, 1'b1};

    always_ff @(posedge ClockA) begin
        rdWord.bytes.lo <= mem[rdLoAddr];
        rdWord.bytes.hi <= mem[rdHiAddr];
    end

    // a host write arriving during the clear must not survive it
    assert property (@(posedge ClockA) disable iff (!rstN)
        clearBusy && wrEn && (wrAddr <= clearIdx) |=> mem[$past(wrAddr)] == 8'h00)
        else $error("frameBuffer: host write accepted while clearing");

    // the scan side must only ask for pixels that exist
    assert property (@(posedge ClockA) disable iff (!rstN)
        rdPixel <= PixelAddrW'(PixelCount - 1))
        else $error("frameBuffer: pixel index out of range");

endmodule

// File: hostWritePort.sv
`timescale 1ns/10ps

module hostWritePort #(
    parameter int PixelWidth  = 64,
    parameter int PixelHeight = 32
) (
    input  logic       ClockA,
    input  logic       rstN,
    input  logic       loadAddr,
    input  logic       writeStrobe,
    input  logic [$clog2(PixelWidth * PixelHeight * pixelPkg::BytesPerPixel)-1:0] hostAddr,
    input  logic [7:0] hostData,
    output logic       wrEn,
    output logic [$clog2(PixelWidth * PixelHeight * pixelPkg::BytesPerPixel)-1:0] wrAddr,
    output logic [7:0] wrData
);
    import pixelPkg::*;

    localparam int ByteCount = PixelWidth * PixelHeight * BytesPerPixel;
    localparam int ByteAddrW = $clog2(ByteCount);
    localparam logic [ByteAddrW-1:0] LastByte = ByteAddrW'(ByteCount - 1);

    logic [ByteAddrW-1:0] bytePtr;

    // pointer advances on every strobe, even while the memory is clearing
    always_ff @(posedge ClockA) begin
        if (!rstN) begin
            bytePtr <= '0;
        end else if (loadAddr) begin
            bytePtr <= hostAddr;
        end else if (writeStrobe) begin
            bytePtr <= (bytePtr == LastByte) ? '0 : bytePtr + 1'b1;
        end
    end

    // write goes out in the strobe cycle at the current pointer
    assign wrEn   = writeStrobe;
    assign wrAddr = bytePtr;
    assign wrData = hostData;

    assert property (@(posedge ClockA) disable iff (!rstN)
        !(loadAddr && writeStrobe))
        else $error("hostWritePort: loadAddr and writeStrobe together");

endmodule

// File: scanTimer.sv
`timescale 1ns/10ps

module scanTimer #(
    parameter int PixelWidth  = 64,
    parameter int PixelHeight = 32,
    parameter int HBlank      = 16,
    parameter int VBlank      = 4
) (
    input  logic                ClockA,
    input  logic                rstN,
    input  logic                clearBusy,
    output logic [$clog2(PixelWidth * PixelHeight)-1:0] rdPixel,
    output videoPkg::videoSyncT scanSync
);
    localparam int HTotal     = PixelWidth + HBlank;
    localparam int VTotal     = PixelHeight + VBlank;
    localparam int ColW       = $clog2(HTotal);
    localparam int LineW      = $clog2(VTotal);
    localparam int PixelAddrW = $clog2(PixelWidth * PixelHeight);

    // position that will be presented on the next cycle
    logic [ColW-1:0]       colCnt;
    logic [LineW-1:0]      lineCnt;
    logic                  colActive;
    logic                  lineActive;
    logic                  lastCol;
    logic                  lastLine;
    logic [PixelAddrW-1:0] pixelIndex;

    assign colActive  = colCnt < ColW'(PixelWidth);
    assign lineActive = lineCnt < LineW'(PixelHeight);
    assign lastCol    = colCnt == ColW'(HTotal - 1);
    assign lastLine   = lineCnt == LineW'(VTotal - 1);

    // linear pixel index, only meaningful inside the active area
    assign pixelIndex = PixelAddrW'(lineCnt) * PixelAddrW'(PixelWidth)
                      + PixelAddrW'(colCnt);

    // held at 0,0 with sync low until the frame memory is clean
    always_ff @(posedge ClockA) begin
        if (!rstN || clearBusy) begin
            colCnt   <= '0;
            lineCnt  <= '0;
            scanSync <= '0;
            rdPixel  <= '0;
        end else begin
            scanSync.active <= colActive && lineActive;
            // hsync covers the whole horizontal blank
            scanSync.hSync  <= !colActive;
            scanSync.vSync  <= !lineActive;
            rdPixel         <= (colActive && lineActive) ? pixelIndex : '0;

            colCnt <= lastCol ? '0 : colCnt + 1'b1;
            if (lastCol) begin
                lineCnt <= lastLine ? '0 : lineCnt + 1'b1;
            end
        end
    end

    assert property (@(posedge ClockA) disable iff (!rstN)
        (colCnt <= ColW'(HTotal - 1)) && (lineCnt <= LineW'(VTotal - 1)))
        else $error("scanTimer: counter past its total");

endmodule

// File: pixelOutputStage.sv
`timescale 1ns/10ps

module pixelOutputStage (
    input  logic                ClockA,
    input  logic                rstN,
    input  videoPkg::videoSyncT scanSync,
    input  pixelPkg::pixelWordT rdWord,
    output videoPkg::videoOutT  videoOut
);
    import pixelPkg::*;
    import videoPkg::*;

    // sync delayed to line up with the memory read
    videoSyncT syncD;
    rgb888T    expanded;

    // top bits repeated into the low bits so full scale stays full scale
    always_comb begin
        expanded.red   = {rdWord.rgb.red, rdWord.rgb.red[4:2]};
        expanded.green = {rdWord.rgb.green, rdWord.rgb.green[5:4]};
        expanded.blue  = {rdWord.rgb.blue, rdWord.rgb.blue[4:2]};
    end

    always_ff @(posedge ClockA) begin
        if (!rstN) begin
            syncD    <= '0;
            videoOut <= '0;
        end else begin
            syncD         <= scanSync;
            videoOut.sync <= syncD;
            // black outside the visible area
            videoOut.rgb  <= syncD.active ? expanded : '0;
        end
    end

endmodule

// File: displayTop.sv
`timescale 1ns/10ps

module displayTop #(
    parameter int PixelWidth  = 64,
    parameter int PixelHeight = 32,
    parameter int HBlank      = 16,
    parameter int VBlank      = 4
) (
    input  logic               ClockA,
    input  logic               rstN,
    input  logic               loadAddr,
    input  logic               writeStrobe,
    input  logic [$clog2(PixelWidth * PixelHeight * pixelPkg::BytesPerPixel)-1:0] hostAddr,
    input  logic [7:0]         hostData,
    output logic               clearBusy,
    output videoPkg::videoOutT videoOut
);
    import pixelPkg::*;
    import videoPkg::*;

    localparam int ByteAddrW  = $clog2(PixelWidth * PixelHeight * BytesPerPixel);
    localparam int PixelAddrW = $clog2(PixelWidth * PixelHeight);

    // host side write request
    logic                  wrEn;
    logic [ByteAddrW-1:0]  wrAddr;
    logic [7:0]            wrData;

    // scan side read path
    logic [PixelAddrW-1:0] rdPixel;
    pixelWordT             rdWord;
    videoSyncT             scanSync;

    hostWritePort #(
        .PixelWidth (PixelWidth),
        .PixelHeight(PixelHeight)
    ) hostPort (
        .ClockA     (ClockA),
        .rstN       (rstN),
        .loadAddr   (loadAddr),
        .writeStrobe(writeStrobe),
        .hostAddr   (hostAddr),
        .hostData   (hostData),
        .wrEn       (wrEn),
        .wrAddr     (wrAddr),
        .wrData     (wrData)
    );

    frameBuffer #(
        .PixelWidth (PixelWidth),
        .PixelHeight(PixelHeight)
    ) frameMem (
        .ClockA   (ClockA),
        .rstN     (rstN),
        .wrEn     (wrEn),
        .wrAddr   (wrAddr),
        .wrData   (wrData),
        .rdPixel  (rdPixel),
        .rdWord   (rdWord),
        .clearBusy(clearBusy)
    );

    scanTimer #(
        .PixelWidth (PixelWidth),
        .PixelHeight(PixelHeight),
        .HBlank     (HBlank),
        .VBlank     (VBlank)
    ) timer (
        .ClockA   (ClockA),
        .rstN     (rstN),
        .clearBusy(clearBusy),
        .rdPixel  (rdPixel),
        .scanSync (scanSync)
    );

    pixelOutputStage outStage (
        .ClockA  (ClockA),
        .rstN    (rstN),
        .scanSync(scanSync),
        .rdWord  (rdWord),
        .videoOut(videoOut)
    );

endmodule

// File: displayTb.sv
`timescale 1ns/10ps

module displayTb;
    import pixelPkg::*;
    import videoPkg::*;

    localparam int PixelWidth  = 64;
    localparam int PixelHeight = 32;
    localparam int HBlank      = 16;
    localparam int VBlank      = 4;
    localparam int HTotal      = PixelWidth + HBlank;
    localparam int VTotal      = PixelHeight + VBlank;
    localparam int FrameCycles = HTotal * VTotal;
    localparam int PixelCount  = PixelWidth * PixelHeight;
    localparam int ByteCount   = PixelCount * BytesPerPixel;
    localparam int ByteAddrW   = $clog2(ByteCount);

    localparam int ResetCycles = 10;
    localparam int ClearCycles = PixelCount * BytesPerPixel;
    // each frame check may wait up to one frame for the vertical edge
    localparam int FrameChecks    = 5;
    localparam int WatchdogCycles = ResetCycles + ClearCycles + FrameChecks * 2 * FrameCycles
                                  + 2000;
    localparam realtime HalfPeriod = 2.0;
    localparam realtime DriveDelay = 0.5;
    localparam int TableLen   = 8;
    localparam int PrintLimit = 8;

    // one host write: pixel position and the RGB565 word stored there
    typedef struct packed {
        logic [7:0]  x;
        logic [7:0]  y;
        logic [15:0] value;
    } stimEntryT;

    logic                 ClockA;
    logic                 rstN;
    logic                 loadAddr;
    logic                 writeStrobe;
    logic [ByteAddrW-1:0] hostAddr;
    logic [7:0]           hostData;
    logic                 clearBusy;
    videoOutT             videoOut;

    stimEntryT   stimTable [TableLen];
    logic [15:0] model [PixelCount];
    int          expPtr;
    int          testIndex;
    int          testErrors;
    int          checkCount;
    int          errorCount;
    int          passedTests;
    int          failedTests;
    string       testName;

    displayTop dut (
        .ClockA     (ClockA),
        .rstN       (rstN),
        .loadAddr   (loadAddr),
        .writeStrobe(writeStrobe),
        .hostAddr   (hostAddr),
        .hostData   (hostData),
        .clearBusy  (clearBusy),
        .videoOut   (videoOut)
    );

    initial ClockA = 1'b0;
    always #HalfPeriod ClockA = ~ClockA;

    initial begin
        repeat (WatchdogCycles) @(posedge ClockA);
        $display("watchdog expired after %0d cycles, tests did not finish", WatchdogCycles);
        $display("Regression failed");
        $finish;
    end

    // 5/6 bit colour widened by shifting it up and filling the gap with its top bits
    function automatic logic [23:0] expandRgb565(input logic [15:0] word);
        logic [4:0] r5;
        logic [5:0] g6;
        logic [4:0] b5;
        logic [7:0] r8;
        logic [7:0] g8;
        logic [7:0] b8;
        r5 = word[15:11];
        g6 = word[10:5];
        b5 = word[4:0];
        r8 = (8'(r5) << 3) | (8'(r5) >> 2);
        g8 = (8'(g6) << 2) | (8'(g6) >> 4);
        b8 = (8'(b5) << 3) | (8'(b5) >> 2);
        return {r8, g8, b8};
    endfunction

    task automatic compareValue(input string sigName, input logic [23:0] got,
                                input logic [23:0] expected, input int line, input int col);
        checkCount++;
        assert (got === expected) else begin
            testErrors++;
            if (testErrors <= PrintLimit) begin
                $display("ERROR %s got %h expected %h (line %0d, column %0d)",
                         sigName, got, expected, line, col);
            end
        end
    endtask

    task automatic checkCondition(input logic cond, input string what);
        checkCount++;
        assert (cond) else begin
            testErrors++;
            $display("%s", what);
        end
    endtask

    task automatic startTest(input string name);
        testIndex++;
        testName   = name;
        testErrors = 0;
    endtask

    task automatic endTest();
        if (testErrors == 0) begin
            passedTests++;
            $display("test %0d %-24s PASS", testIndex, testName);
        end else begin
            failedTests++;
            errorCount += testErrors;
            $display("test %0d %-24s FAIL (%0d errors)", testIndex, testName, testErrors);
        end
    endtask

    // reference memory keeps bytes inside pixel words, low byte at even address
    task automatic modelWriteByte(input int addr, input logic [7:0] data);
        int px;
        px = addr / 2;
        if (addr % 2 == 1) begin
            model[px][15:8] = data;
        end else begin
            model[px][7:0] = data;
        end
    endtask

    // called at a drive point, leaves the next drive point behind
    task automatic loadPointer(input int addr);
        loadAddr = 1'b1;
        hostAddr = addr[ByteAddrW-1:0];
        expPtr   = addr;
        @(posedge ClockA);
        #DriveDelay;
        loadAddr = 1'b0;
    endtask

    task automatic writeByte(input logic [7:0] data);
        writeStrobe = 1'b1;
        hostData    = data;
        modelWriteByte(expPtr, data);
        expPtr = (expPtr + 1) % ByteCount;
        @(posedge ClockA);
        #DriveDelay;
        writeStrobe = 1'b0;
    endtask

    task automatic syncToDrive();
        @(posedge ClockA);
        #DriveDelay;
    endtask

    task automatic fillTable();
        stimTable[0] = '{8'd0, 8'd0, 16'hFFFF};
        stimTable[1] = '{8'd63, 8'd0, 16'hF800};
        stimTable[2] = '{8'd0, 8'd31, 16'h07E0};
        stimTable[3] = '{8'd63, 8'd31, 16'h001F};
        stimTable[4] = '{8'd5, 8'd3, 16'h0000};
        stimTable[5] = '{8'd17, 8'd12, 16'h0000};
        stimTable[6] = '{8'd40, 8'd20, 16'h0000};
        stimTable[7] = '{8'd33, 8'd7, 16'h0000};
        for (int i = 4; i < TableLen; i++) begin
            stimTable[i].value = 16'($urandom);
        end
    endtask

    // waits for vSync to fall on videoOut, then checks one whole frame
    task automatic checkFrame();
        int   waitCycles;
        int   line;
        int   col;
        int   activeSeen;
        int   lineActive;
        int   lineHSync;
        int   vSyncCycles;
        logic prevV;
        logic expActive;
        logic [23:0] expRgb;
        waitCycles = 0;
        prevV      = videoOut.sync.vSync;
        @(negedge ClockA);
        while (!(prevV && !videoOut.sync.vSync) && waitCycles < 2 * FrameCycles) begin
            prevV = videoOut.sync.vSync;
            @(negedge ClockA);
            waitCycles++;
        end
        checkCondition(waitCycles < 2 * FrameCycles,
                       "no falling edge of vSync seen on videoOut within two frames");
        activeSeen  = 0;
        lineActive  = 0;
        lineHSync   = 0;
        vSyncCycles = 0;
        for (int cyc = 0; cyc < FrameCycles; cyc++) begin
            line      = cyc / HTotal;
            col       = cyc % HTotal;
            expActive = (line < PixelHeight) && (col < PixelWidth);
            compareValue("videoOut.sync.active", 24'(videoOut.sync.active), 24'(expActive),
                         line, col);
            compareValue("videoOut.sync.hSync", 24'(videoOut.sync.hSync),
                         24'(col >= PixelWidth), line, col);
            compareValue("videoOut.sync.vSync", 24'(videoOut.sync.vSync),
                         24'(line >= PixelHeight), line, col);
            if (videoOut.sync.active) begin
                expRgb = expandRgb565(model[activeSeen]);
                activeSeen++;
                lineActive++;
            end else begin
                expRgb = '0;
            end
            compareValue("videoOut.rgb", videoOut.rgb, expRgb, line, col);
            if (videoOut.sync.hSync) begin
                lineHSync++;
            end
            if (videoOut.sync.vSync) begin
                vSyncCycles++;
            end
            if (col == HTotal - 1) begin
                compareValue("active beats per line", 24'(lineActive),
                             24'((line < PixelHeight) ? PixelWidth : 0), line, col);
                compareValue("hSync cycles per line", 24'(lineHSync), 24'(HBlank), line, col);
                lineActive = 0;
                lineHSync  = 0;
            end
            @(negedge ClockA);
        end
        compareValue("active beats per frame", 24'(activeSeen), 24'(PixelCount), VTotal, 0);
        compareValue("vSync lines per frame", 24'(vSyncCycles / HTotal), 24'(VBlank), VTotal, 0);
    endtask

    initial begin
        int  busyCycles;
        int  pixelIdx;
        logic busyDone;
        rstN        = 1'b0;
        loadAddr    = 1'b0;
        writeStrobe = 1'b0;
        hostAddr    = '0;
        hostData    = '0;
        expPtr      = 0;
        testIndex   = 0;
        checkCount  = 0;
        errorCount  = 0;
        passedTests = 0;
        failedTests = 0;
        void'($urandom(32'h8cb7));
        fillTable();
        for (int i = 0; i < PixelCount; i++) begin
            model[i] = 16'h0000;
        end

        startTest("reset and clear");
        for (int i = 0; i < ResetCycles; i++) begin
            @(negedge ClockA);
            compareValue("videoOut.sync", 24'(videoOut.sync), 24'h0, 0, 0);
            compareValue("videoOut.rgb", videoOut.rgb, 24'h0, 0, 0);
            compareValue("clearBusy", 24'(clearBusy), 24'h1, 0, 0);
        end
        syncToDrive();
        rstN = 1'b1;
        busyCycles = 0;
        busyDone   = 1'b0;
        while (!busyDone) begin
            @(negedge ClockA);
            if (clearBusy === 1'b1) begin
                busyCycles++;
                compareValue("videoOut.sync", 24'(videoOut.sync), 24'h0, 0, 0);
                compareValue("videoOut.rgb", videoOut.rgb, 24'h0, 0, 0);
            end else begin
                busyDone = 1'b1;
            end
            if (busyCycles > ClearCycles + 16) begin
                checkCondition(1'b0, "clearBusy stayed high well past the clear length");
                busyDone = 1'b1;
            end
        end
        compareValue("clearBusy high cycles", 24'(busyCycles), 24'(ClearCycles), 0, 0);
        checkFrame();
        endTest();

        startTest("written pixels");
        syncToDrive();
        for (int i = 0; i < TableLen; i++) begin
            pixelIdx = int'(stimTable[i].y) * PixelWidth + int'(stimTable[i].x);
            loadPointer(2 * pixelIdx);
            writeByte(stimTable[i].value[7:0]);
            writeByte(stimTable[i].value[15:8]);
        end
        checkFrame();
        endTest();

        // last byte, then wrap into pixel 0
        startTest("auto-increment and wrap");
        syncToDrive();
        loadPointer(ByteCount - 1);
        writeByte(8'h3C);
        writeByte(8'hC3);
        writeByte(8'h5A);
        checkFrame();
        endTest();

        // high byte only, low half of the pixel must survive
        startTest("single-byte overwrite");
        syncToDrive();
        pixelIdx = 12 * PixelWidth + 17;
        loadPointer(2 * pixelIdx + 1);
        writeByte(8'hA5);
        checkFrame();
        endTest();

        startTest("video timing");
        checkFrame();
        endTest();

        $display("tests %0d, passed %0d, failed %0d, checks %0d, errors %0d",
                 testIndex, passedTests, failedTests, checkCount, errorCount);
        if (failedTests == 0 && errorCount == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: sources.f
pixelPkg.sv
videoPkg.sv
frameBuffer.sv
hostWritePort.sv
scanTimer.sv
pixelOutputStage.sv
displayTop.sv
displayTb.sv

// File: run.sh
#!/bin/sh
# compile and run the display controller testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert --top-module displayTb -f sources.f -o displaySim

./obj_dir/displaySim | tee sim.log

if grep -qx "Regression passed" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see sim.log"
    exit 1
fi
